//--- verilog/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;  // {group tag, opcode or funct}
    localparam int ALUSEL_W   = 3;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // jal writes ra

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ALU class seen by the execute stage
    localparam logic [ALUSEL_W-1:0] SEL_NOP    = 3'd0;
    localparam logic [ALUSEL_W-1:0] SEL_LOGIC  = 3'd1;
    localparam logic [ALUSEL_W-1:0] SEL_SHIFT  = 3'd2;
    localparam logic [ALUSEL_W-1:0] SEL_ARITH  = 3'd3;
    localparam logic [ALUSEL_W-1:0] SEL_JUMP   = 3'd4;
    localparam logic [ALUSEL_W-1:0] SEL_BRANCH = 3'd5;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [REG_ADDR_W-1:0] shamt;
            logic [5:0]            funct;
        } r_fmt;
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm16;
        } i_fmt;
        struct packed {
            logic [5:0]  op;
            logic [25:0] index26;
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- verilog/id_if.sv
`timescale 1ns/1ps
`default_nettype none

// raw decode fields, classifier to operand mux
interface dec_if import id_pkg::*; ();
    logic [ALUOP_W-1:0]    aluop;
    logic [ALUSEL_W-1:0]   alusel;
    logic                  reg1_read;
    logic                  reg2_read;
    logic                  need_sa;    // operand 1 is the shift amount
    logic [REG_ADDR_W-1:0] shamt;
    logic [REG_W-1:0]      imm;        // zero-extended imm16 or index26
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic                  is_jump;
    logic                  is_branch;

    modport producer (
        output aluop, alusel, reg1_read, reg2_read, need_sa, shamt,
        output imm, wd, wreg, is_jump, is_branch
    );
    modport consumer (
        input aluop, alusel, reg1_read, reg2_read, need_sa, shamt,
        input imm, wd, wreg, is_jump, is_branch
    );
endinterface

// final operands and control into the ID/EX register
interface ex_if import id_pkg::*; ();
    logic [ALUOP_W-1:0]    aluop;
    logic [ALUSEL_W-1:0]   alusel;
    logic [REG_W-1:0]      reg1;
    logic [REG_W-1:0]      reg2;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;       // already masked by the scoreboard
    logic [REG_W-1:0]      offset;
    logic                  pc_flush;

    modport producer (output aluop, alusel, reg1, reg2, wd, wreg, offset, pc_flush);
    modport consumer (input aluop, alusel, reg1, reg2, wd, wreg, offset, pc_flush);
endinterface

`default_nettype wire

//--- verilog/inst_classify.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classify import id_pkg::*; (
    input  instr_u  inst_i,
    dec_if.producer dec
);

    logic [5:0]            op;
    logic [5:0]            fn;
    logic                  is_nop;
    logic                  r_type;
    logic                  i_type;
    logic                  j_type;
    logic                  is_logic;
    logic                  is_shift;
    logic                  is_arith;
    logic                  is_jump;
    logic                  is_branch;
    logic                  is_jr;
    logic                  is_jal;
    logic                  is_beq_bne;
    logic                  wreg_pre;
    logic [REG_ADDR_W-1:0] dest;

    assign op     = inst_i.r_fmt.op;
    assign fn     = inst_i.r_fmt.funct;
    assign is_nop = (inst_i == '0);  // sll r0,r0,0 taken as a true nop

    always_comb begin
        r_type    = 1'b0;
        i_type    = 1'b0;
        j_type    = 1'b0;
        is_logic  = 1'b0;
        is_shift  = 1'b0;
        is_arith  = 1'b0;
        is_jump   = 1'b0;
        is_branch = 1'b0;
        if (op == OP_SPECIAL && !is_nop) begin
            r_type = 1'b1;
            case (fn)
                FN_AND, FN_OR, FN_XOR, FN_NOR:                      is_logic = 1'b1;
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: is_shift = 1'b1;
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: is_arith = 1'b1;
                FN_JR, FN_JALR:                                     is_jump  = 1'b1;
                default:                                            r_type   = 1'b0;
            endcase
        end else begin
            case (op)
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    i_type   = 1'b1;
                    is_logic = 1'b1;
                end
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                    i_type   = 1'b1;
                    is_arith = 1'b1;
                end
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                    i_type    = 1'b1;
                    is_branch = 1'b1;
                end
                OP_J, OP_JAL: begin
                    j_type  = 1'b1;
                    is_jump = 1'b1;
                end
                default: ;  // unknown word, every flag stays low
            endcase
        end
    end

    assign is_jr      = r_type && fn == FN_JR;
    assign is_jal     = j_type && op == OP_JAL;
    assign is_beq_bne = i_type && (op == OP_BEQ || op == OP_BNE);

    // rd for R, rt for I, ra for jal
    always_comb begin
        if (r_type) begin
            dest = inst_i.r_fmt.rd;
        end else if (is_jal) begin
            dest = LINK_REG;
        end else if (i_type) begin
            dest = inst_i.i_fmt.rt;
        end else begin
            dest = '0;
        end
    end

    assign wreg_pre = (r_type && !is_jr) || (i_type && !is_branch) || is_jal;

    always_comb begin
        if (is_logic) begin
            dec.alusel = SEL_LOGIC;
        end else if (is_shift) begin
            dec.alusel = SEL_SHIFT;
        end else if (is_arith) begin
            dec.alusel = SEL_ARITH;
        end else if (is_jump) begin
            dec.alusel = SEL_JUMP;
        end else if (is_branch) begin
            dec.alusel = SEL_BRANCH;
        end else begin
            dec.alusel = SEL_NOP;
        end
    end

    assign dec.aluop = r_type            ? {2'b01, fn} :
                       (i_type || j_type) ? {2'b00, op} : '0;

    assign dec.reg1_read = r_type || i_type;
    assign dec.reg2_read = r_type || is_beq_bne;
    assign dec.need_sa   = r_type && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
    assign dec.shamt     = r_type ? inst_i.r_fmt.shamt : '0;

    assign dec.imm = i_type ? {16'h0, inst_i.i_fmt.imm16} :
                     j_type ? {6'h0, inst_i.j_fmt.index26} : '0;

    assign dec.wd        = dest;
    assign dec.wreg      = wreg_pre && dest != '0;  // writes to r0 are dropped here
    assign dec.is_jump   = is_jump;
    assign dec.is_branch = is_branch;

endmodule

`default_nettype wire

//--- verilog/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import id_pkg::*; (
    dec_if.consumer          dec,
    input  logic [REG_W-1:0] rf_data1_i,
    input  logic [REG_W-1:0] rf_data2_i,
    input  logic             oitf_match_i,  // outstanding write to our destination
    ex_if.producer           ex
);

    logic             nop_sel;
    logic [REG_W-1:0] reg1_pre;
    logic [REG_W-1:0] reg2_pre;

    assign nop_sel = (dec.alusel == SEL_NOP);

    // shift amount wins over register data for sll/srl/sra
    always_comb begin
        if (dec.need_sa) begin
            reg1_pre = REG_W'(dec.shamt);
        end else if (dec.reg1_read) begin
            reg1_pre = rf_data1_i;
        end else begin
            reg1_pre = dec.imm;
        end
    end

    assign reg2_pre = dec.reg2_read ? rf_data2_i : dec.imm;

    assign ex.reg1 = nop_sel ? '0 : reg1_pre;
    assign ex.reg2 = nop_sel ? '0 : reg2_pre;

    assign ex.aluop    = dec.aluop;
    assign ex.alusel   = dec.alusel;
    assign ex.wd       = dec.wd;
    assign ex.wreg     = dec.wreg && !oitf_match_i;
    assign ex.offset   = dec.is_branch ? dec.imm : '0;  // word offset, EX scales it
    assign ex.pc_flush = dec.is_jump || dec.is_branch;

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [REG_W-1:0]      rdata1_o,
    output logic [REG_W-1:0]      rdata2_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [REG_W-1:0]      wdata_i
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [REG_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // r0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a write shows up after the edge
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    // write-back must name a real register whenever it writes
    waddr_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

//--- verilog/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic [REG_W-1:0]      pc_i,
    ex_if.consumer                ex,
    output logic [REG_W-1:0]      ex_pc_o,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [REG_W-1:0]      ex_reg1_o,
    output logic [REG_W-1:0]      ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic [REG_W-1:0]      ex_offset_o,
    output logic                  ex_pc_flush_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_pc_o       <= '0;
            ex_aluop_o    <= '0;
            ex_alusel_o   <= SEL_NOP;
            ex_reg1_o     <= '0;
            ex_reg2_o     <= '0;
            ex_wd_o       <= '0;
            ex_wreg_o     <= 1'b0;
            ex_offset_o   <= '0;
            ex_pc_flush_o <= 1'b0;
        end else if (!stall_i) begin  // hold everything while stalled
            ex_pc_o       <= pc_i;
            ex_aluop_o    <= ex.aluop;
            ex_alusel_o   <= ex.alusel;
            ex_reg1_o     <= ex.reg1;
            ex_reg2_o     <= ex.reg2;
            ex_wd_o       <= ex.wd;
            ex_wreg_o     <= ex.wreg;
            ex_offset_o   <= ex.offset;
            ex_pc_flush_o <= ex.pc_flush;
        end
    end

    // classifier only emits the six defined classes
    alusel_range_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_alusel_o <= SEL_BRANCH);

    // a write enable never reaches EX aimed at r0
    wreg_dest_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_wreg_o |-> ex_wd_o != '0);

endmodule

`default_nettype wire

//--- verilog/mips_id_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_id_top import id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_W-1:0]      inst_i,
    input  logic [REG_W-1:0]      pc_i,
    input  logic                  stall_i,
    input  logic                  oitf_match_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [REG_W-1:0]      wb_data_i,
    output logic [REG_W-1:0]      ex_pc_o,
    output logic [ALUOP_W-1:0]    ex_aluop_o,
    output logic [ALUSEL_W-1:0]   ex_alusel_o,
    output logic [REG_W-1:0]      ex_reg1_o,
    output logic [REG_W-1:0]      ex_reg2_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_wreg_o,
    output logic [REG_W-1:0]      ex_offset_o,
    output logic                  ex_pc_flush_o
);

    instr_u           inst_w;
    logic [REG_W-1:0] rf_data1;
    logic [REG_W-1:0] rf_data2;

    assign inst_w = inst_i;

    dec_if dec_bus ();
    ex_if  ex_bus ();

    inst_classify inst_classify_inst (
        .inst_i (inst_w),
        .dec    (dec_bus)
    );

    // rs and rt read straight from the word, decode runs in parallel
    regfile regfile_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (inst_w.r_fmt.rs),
        .raddr2_i (inst_w.r_fmt.rt),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i)
    );

    operand_select operand_select_inst (
        .dec          (dec_bus),
        .rf_data1_i   (rf_data1),
        .rf_data2_i   (rf_data2),
        .oitf_match_i (oitf_match_i),
        .ex           (ex_bus)
    );

    id_ex_reg id_ex_reg_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .pc_i          (pc_i),
        .ex            (ex_bus),
        .ex_pc_o       (ex_pc_o),
        .ex_aluop_o    (ex_aluop_o),
        .ex_alusel_o   (ex_alusel_o),
        .ex_reg1_o     (ex_reg1_o),
        .ex_reg2_o     (ex_reg2_o),
        .ex_wd_o       (ex_wd_o),
        .ex_wreg_o     (ex_wreg_o),
        .ex_offset_o   (ex_offset_o),
        .ex_pc_flush_o (ex_pc_flush_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_mips_id.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_id import id_pkg::*; ();

    localparam int MAX_CYCLES = 400;  // tests need well under half of this

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic [REG_W-1:0]      inst_i;
    logic [REG_W-1:0]      pc_i;
    logic                  stall_i;
    logic                  oitf_match_i;
    logic                  wb_we_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [REG_W-1:0]      wb_data_i;
    logic [REG_W-1:0]      ex_pc_o;
    logic [ALUOP_W-1:0]    ex_aluop_o;
    logic [ALUSEL_W-1:0]   ex_alusel_o;
    logic [REG_W-1:0]      ex_reg1_o;
    logic [REG_W-1:0]      ex_reg2_o;
    logic [REG_ADDR_W-1:0] ex_wd_o;
    logic                  ex_wreg_o;
    logic [REG_W-1:0]      ex_offset_o;
    logic                  ex_pc_flush_o;

    logic [REG_W-1:0] rf_model [32];  // expected register contents
    int               cycle_count = 0;

    mips_id_top mips_id_top_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        instr_u w;
        w.r_fmt = '{op: OP_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: sa, funct: fn};
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        instr_u w;
        w.i_fmt = '{op: op, rs: rs, rt: rt, imm16: imm};
        return w;
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] idx);
        instr_u w;
        w.j_fmt = '{op: op, index26: idx};
        return w;
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb_we_i   <= 1'b1;
        wb_addr_i <= addr;
        wb_data_i <= data;
        @(posedge clk);
        wb_we_i   <= 1'b0;
        if (addr != 5'd0) rf_model[addr] = data;  // r0 never changes
    endtask

    // drive one word, let the ID/EX register take it, sample mid-cycle
    task automatic issue(input logic [31:0] word, input logic [31:0] pc, input logic oitf);
        @(posedge clk);
        inst_i       <= word;
        pc_i         <= pc;
        oitf_match_i <= oitf;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_rtype(input string name, input logic [5:0] fn,
                               input logic [2:0] sel, input logic [4:0] rd,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic wreg);
        check_value({name, " reg1"}, a, ex_reg1_o);
        check_value({name, " reg2"}, b, ex_reg2_o);
        check_value({name, " aluop"}, {24'h0, 2'b01, fn}, 32'(ex_aluop_o));
        check_value({name, " alusel"}, 32'(sel), 32'(ex_alusel_o));
        check_value({name, " wd"}, 32'(rd), 32'(ex_wd_o));
        check_value({name, " wreg"}, 32'(wreg), 32'(ex_wreg_o));
    endtask

    task automatic check_itype(input string name, input logic [5:0] op,
                               input logic [2:0] sel, input logic [15:0] imm);
        issue(i_word(op, 5'd5, 5'd9, imm), 32'h100, 1'b0);
        check_value({name, " reg1"}, rf_model[5], ex_reg1_o);
        check_value({name, " reg2"}, {16'h0, imm}, ex_reg2_o);
        check_value({name, " aluop"}, {24'h0, 2'b00, op}, 32'(ex_aluop_o));
        check_value({name, " alusel"}, 32'(sel), 32'(ex_alusel_o));
        check_value({name, " wd"}, 32'd9, 32'(ex_wd_o));
        check_value({name, " wreg"}, 32'd1, 32'(ex_wreg_o));
    endtask

    task automatic test_reset_r0();
        check_value("reset wreg", 32'd0, 32'(ex_wreg_o));
        check_value("reset flush", 32'd0, 32'(ex_pc_flush_o));
        check_value("reset alusel", 32'(SEL_NOP), 32'(ex_alusel_o));
        write_reg(5'd0, $urandom);
        issue(r_word(5'd0, 5'd0, 5'd3, 5'd0, FN_ADDU), 32'h40, 1'b0);
        check_rtype("r0 addu", FN_ADDU, SEL_ARITH, 5'd3, 32'h0, 32'h0, 1'b1);
    endtask

    task automatic test_rtype();
        write_reg(5'd5, $urandom);
        write_reg(5'd6, $urandom);
        issue(r_word(5'd5, 5'd6, 5'd7, 5'd0, FN_ADDU), 32'h44, 1'b0);
        check_rtype("addu", FN_ADDU, SEL_ARITH, 5'd7, rf_model[5], rf_model[6], 1'b1);
        issue(r_word(5'd5, 5'd6, 5'd8, 5'd0, FN_SUB), 32'h48, 1'b0);
        check_rtype("sub", FN_SUB, SEL_ARITH, 5'd8, rf_model[5], rf_model[6], 1'b1);
        issue(r_word(5'd5, 5'd6, 5'd12, 5'd0, FN_SLT), 32'h4c, 1'b0);
        check_rtype("slt", FN_SLT, SEL_ARITH, 5'd12, rf_model[5], rf_model[6], 1'b1);
        issue(r_word(5'd5, 5'd6, 5'd20, 5'd0, FN_AND), 32'h50, 1'b0);
        check_rtype("and", FN_AND, SEL_LOGIC, 5'd20, rf_model[5], rf_model[6], 1'b1);
        issue(r_word(5'd5, 5'd6, 5'd30, 5'd0, FN_NOR), 32'h54, 1'b0);
        check_rtype("nor", FN_NOR, SEL_LOGIC, 5'd30, rf_model[5], rf_model[6], 1'b1);
    endtask

    task automatic test_itype();
        check_itype("ori", OP_ORI, SEL_LOGIC, 16'($urandom));
        check_itype("addiu", OP_ADDIU, SEL_ARITH, 16'($urandom));
        check_itype("slti", OP_SLTI, SEL_ARITH, 16'($urandom));
        check_itype("lui", OP_LUI, SEL_LOGIC, 16'($urandom));
    endtask

    task automatic test_shift_nop();
        issue(r_word(5'd5, 5'd6, 5'd8, 5'd13, FN_SLL), 32'h60, 1'b0);
        check_rtype("sll", FN_SLL, SEL_SHIFT, 5'd8, 32'd13, rf_model[6], 1'b1);
        issue(r_word(5'd5, 5'd6, 5'd8, 5'd0, FN_SLLV), 32'h64, 1'b0);
        check_rtype("sllv", FN_SLLV, SEL_SHIFT, 5'd8, rf_model[5], rf_model[6], 1'b1);
        issue(32'h0, 32'h68, 1'b0);
        check_value("nop alusel", 32'(SEL_NOP), 32'(ex_alusel_o));
        check_value("nop reg1", 32'h0, ex_reg1_o);
        check_value("nop reg2", 32'h0, ex_reg2_o);
        check_value("nop wreg", 32'd0, 32'(ex_wreg_o));
    endtask

    task automatic test_jump_branch();
        logic [25:0] idx;
        logic [15:0] imm;
        logic [31:0] pc;
        idx = 26'($urandom);
        imm = 16'($urandom);
        pc  = {$urandom} & 32'hffff_fffc;
        issue(j_word(OP_J, idx), pc, 1'b0);
        check_value("j flush", 32'd1, 32'(ex_pc_flush_o));
        check_value("j reg1", {6'h0, idx}, ex_reg1_o);
        check_value("j wreg", 32'd0, 32'(ex_wreg_o));
        check_value("j pc", pc, ex_pc_o);
        issue(j_word(OP_JAL, idx), pc + 32'd4, 1'b0);
        check_value("jal wd", 32'd31, 32'(ex_wd_o));
        check_value("jal wreg", 32'd1, 32'(ex_wreg_o));
        check_value("jal pc", pc + 32'd4, ex_pc_o);
        issue(i_word(OP_BEQ, 5'd5, 5'd6, imm), pc + 32'd8, 1'b0);
        check_value("beq offset", {16'h0, imm}, ex_offset_o);
        check_value("beq reg2", rf_model[6], ex_reg2_o);
        check_value("beq flush", 32'd1, 32'(ex_pc_flush_o));
        check_value("beq wreg", 32'd0, 32'(ex_wreg_o));
        check_value("beq pc", pc + 32'd8, ex_pc_o);
    endtask

    task automatic test_hazard_stall();
        logic [15:0] imm;
        imm = 16'($urandom) | 16'h1;  // nonzero so a lost hold shows on the offset
        issue(r_word(5'd5, 5'd6, 5'd7, 5'd0, FN_ADDU), 32'h80, 1'b1);
        check_rtype("hazard addu", FN_ADDU, SEL_ARITH, 5'd7, rf_model[5], rf_model[6], 1'b0);
        issue(r_word(5'd5, 5'd6, 5'd10, 5'd0, FN_ADDU), 32'h84, 1'b0);
        @(posedge clk);
        stall_i <= 1'b1;
        inst_i  <= i_word(OP_BEQ, 5'd6, 5'd5, imm);
        pc_i    <= 32'h88;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_rtype("stall hold", FN_ADDU, SEL_ARITH, 5'd10, rf_model[5], rf_model[6], 1'b1);
        check_value("stall offset", 32'h0, ex_offset_o);
        check_value("stall flush", 32'd0, 32'(ex_pc_flush_o));
        check_value("stall pc", 32'h84, ex_pc_o);
        @(posedge clk);
        stall_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("after stall aluop", {24'h0, 2'b00, OP_BEQ}, 32'(ex_aluop_o));
        check_value("after stall alusel", 32'(SEL_BRANCH), 32'(ex_alusel_o));
        check_value("after stall reg1", rf_model[6], ex_reg1_o);
        check_value("after stall reg2", rf_model[5], ex_reg2_o);
        check_value("after stall offset", {16'h0, imm}, ex_offset_o);
        check_value("after stall flush", 32'd1, 32'(ex_pc_flush_o));
        check_value("after stall wreg", 32'd0, 32'(ex_wreg_o));
        check_value("after stall pc", 32'h88, ex_pc_o);
    endtask

    initial begin
        void'($urandom(32'h6e5b));
        for (int i = 0; i < 32; i++) rf_model[i] = '0;
        rst_n_i      <= 1'b0;
        inst_i       <= '0;
        pc_i         <= '0;
        stall_i      <= 1'b0;
        oitf_match_i <= 1'b0;
        wb_we_i      <= 1'b0;
        wb_addr_i    <= '0;
        wb_data_i    <= '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        test_reset_r0();
        test_rtype();
        test_itype();
        test_shift_nop();
        test_jump_branch();
        test_hazard_stall();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/id_pkg.sv
verilog/id_if.sv
verilog/inst_classify.sv
verilog/operand_select.sv
verilog/regfile.sv
verilog/id_ex_reg.sv
verilog/mips_id_top.sv
dv/tb_mips_id.sv

//--- Makefile
SIM   ?= verilator
TOP   ?= tb_mips_id
LOG   ?= sim.log
FLIST ?= vlog.f
BUILD ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) --binary --timing --assert -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@if grep -qx "Finished with no errors" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
